// File: lsi11.f
src/lsi11_pkg.sv
src/lsi11_dec_if.sv
src/lsi11_dp_if.sv
src/lsi11_decoder.sv
src/lsi11_control.sv
src/lsi11_alu.sv
src/lsi11_datapath.sv
src/lsi11_core.sv
verification/lsi11_tb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --top-module lsi11_tb -f lsi11.f -o lsi11_sim &&
./obj_dir/lsi11_sim || exit 1

// File: verification/lsi11_tb.sv
`timescale 1ns/1ns
`default_nettype none

module lsi11_tb import lsi11_pkg::*; ();

    localparam word_t       DATA_A         = 16'o000100;  // destination word of every row
    localparam word_t       DATA_B         = 16'o000102;  // word after it, target of mov #bad
    localparam word_t       BAD_WORD       = 16'hdead;
    localparam word_t       MOV_IMM_R1     = 16'o012701;  // mov #n,r1
    localparam word_t       MOV_IMM_AI     = 16'o012721;  // mov #n,(r1)+
    localparam word_t       NO_BRANCH      = 16'h0000;
    localparam word_t       NO_WRITE       = 16'h0000;
    localparam int          TIMEOUT_CYCLES = 400;
    localparam logic [31:0] RAND_SEED      = 32'h323e_deb5;

    typedef struct packed {
        word_t instr;      // on #src,(r1)+ or on (r1)+
        word_t branch;
        word_t src;
        word_t dst;        // initial word at DATA_A
        word_t exp_word;   // expected word at wr_addr
        cc_t   exp_cc;
        word_t wr_addr;
    } test_row_t;

    logic  clk = 1'b0;
    logic  reset_n;
    word_t bus_rdata_i;
    logic  bus_rply_i;
    word_t bus_addr_o;
    word_t bus_wdata_o;
    logic  bus_rd_o;
    logic  bus_wr_o;
    logic  halted_o;
    cc_t   cc_o;

    test_row_t rows [$];
    word_t     mem [64];
    logic      wr_flag [64];
    int        wr_total;
    int        rd_total;
    int        reply_delay;    // idle cycles left before the reply, -1 when idle
    word_t     halt_addr;
    logic      halt_fetched;

    lsi11_core uut (
        .clk         (clk),
        .reset_n     (reset_n),
        .bus_rdata_i (bus_rdata_i),
        .bus_rply_i  (bus_rply_i),
        .bus_addr_o  (bus_addr_o),
        .bus_wdata_o (bus_wdata_o),
        .bus_rd_o    (bus_rd_o),
        .bus_wr_o    (bus_wr_o),
        .halted_o    (halted_o),
        .cc_o        (cc_o)
    );

    always #4 clk = ~clk;

    function automatic logic [5:0] word_index(input word_t addr);
        return addr[6:1];
    endfunction

    task automatic fail_with(input string msg);
        $display("%s", msg);
        $display("Result: FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_value(input string name, input word_t got, input word_t exp);
        if (got !== exp)
            fail_with($sformatf("CHECK FAILED at %0t ns: %s = %h, expected %h",
                                $time, name, got, exp));
    endtask

    task automatic add_row(input word_t instr, input word_t branch, input word_t src,
                           input word_t dst, input word_t exp_word, input cc_t exp_cc,
                           input word_t wr_addr);
        test_row_t row;
        row = '{instr, branch, src, dst, exp_word, exp_cc, wr_addr};
        rows.push_back(row);
    endtask

    // ====================
    // memory model
    task automatic complete_transfer();
        word_t addr;
        addr = bus_addr_o;
        if (bus_rd_o && bus_wr_o)
            fail_with("bus_rd_o and bus_wr_o are high in the same cycle");
        if (addr[15:7] != '0 || addr[0])
            fail_with($sformatf("bus access at %h lies outside the memory model", addr));
        if (rd_total == 0 && wr_total == 0) begin   // first transfer after reset
            check_value("first bus_rd_o", 16'(bus_rd_o), 16'h0001);
            check_value("first bus_addr_o", addr, BOOT_PC);
        end
        if (bus_rd_o) begin
            bus_rdata_i = mem[word_index(addr)];
            rd_total++;
            if (addr == halt_addr)
                halt_fetched = 1'b1;
        end else begin
            mem[word_index(addr)]     = bus_wdata_o;
            wr_flag[word_index(addr)] = 1'b1;
            wr_total++;
        end
    endtask

    task automatic serve_bus();
        if (!reset_n) begin
            bus_rply_i  = 1'b0;
            reply_delay = -1;
        end else if (bus_rply_i) begin
            if (bus_rd_o || bus_wr_o)
                fail_with("bus strobe still high in the cycle after the reply");
            bus_rply_i  = 1'b0;                      // reply lasts one cycle
            reply_delay = -1;
        end else if (bus_rd_o || bus_wr_o) begin
            if (reply_delay < 0)
                reply_delay = int'($urandom % 4);
            if (reply_delay == 0) begin
                complete_transfer();
                bus_rply_i = 1'b1;
            end else begin
                reply_delay = reply_delay - 1;
            end
        end
    endtask

    task automatic step_cycle();
        @(negedge clk);
        serve_bus();
    endtask

    task automatic load_program(input test_row_t row);
        int         i;
        logic [5:0] idx;
        logic [5:0] w;
        for (i = 0; i < 64; i++) begin
            idx          = 6'(i);
            mem[idx]     = {4'hf, idx, idx};
            wr_flag[idx] = 1'b0;
        end
        mem[0] = MOV_IMM_R1;
        mem[1] = DATA_A;
        mem[2] = row.instr;
        w      = 6'd3;
        if (row.instr[15:12] != 4'h0) begin     // double operand takes #src
            mem[w] = row.src;
            w      = w + 6'd1;
        end
        if (row.branch != NO_BRANCH) begin
            mem[w]        = row.branch;
            mem[w + 6'd1] = MOV_IMM_AI;
            mem[w + 6'd2] = BAD_WORD;
            w             = w + 6'd3;
        end
        mem[w]                   = 16'h0000;    // halt
        halt_addr                = {9'b0, w, 1'b0};
        mem[word_index(DATA_A)]  = row.dst;
        wr_total                 = 0;
        rd_total                 = 0;
        halt_fetched             = 1'b0;
    endtask

    task automatic run_row(input int r);
        test_row_t row;
        int        cycles;
        row = rows[r];
        step_cycle();
        reset_n = 1'b0;
        load_program(row);
        repeat (3) step_cycle();
        check_value("halted_o in reset", 16'(halted_o), 16'h0000);
        check_value("bus_rd_o in reset", 16'(bus_rd_o), 16'h0000);
        check_value("bus_wr_o in reset", 16'(bus_wr_o), 16'h0000);
        check_value("cc_o in reset", 16'(cc_o), 16'h0000);
        reset_n = 1'b1;

        cycles = 0;
        while (!halted_o) begin
            if (cycles == TIMEOUT_CYCLES)
                fail_with($sformatf("timeout: row %0d never raised halted_o", r));
            step_cycle();
            cycles++;
            if (halted_o && !halt_fetched)
                fail_with($sformatf("row %0d: halted_o rose before HALT was read", r));
        end
        repeat (4) begin                         // halted holds with an idle bus
            step_cycle();
            check_value("halted_o", 16'(halted_o), 16'h0001);
            check_value("bus strobes when halted", 16'(bus_rd_o | bus_wr_o), 16'h0000);
        end

        check_value("cc_o", 16'(cc_o), 16'(row.exp_cc));
        check_value("write count", 16'(wr_total), (row.wr_addr != NO_WRITE) ? 16'd1 : 16'd0);
        check_value("write at A", 16'(wr_flag[word_index(DATA_A)]),
                    (row.wr_addr == DATA_A) ? 16'd1 : 16'd0);
        check_value("write at A+2", 16'(wr_flag[word_index(DATA_B)]),
                    (row.wr_addr == DATA_B) ? 16'd1 : 16'd0);
        if (row.wr_addr != NO_WRITE)
            check_value("memory word written", mem[word_index(row.wr_addr)], row.exp_word);
    endtask

    // ====================
    // stimulus table and run
    initial begin
        reset_n     = 1'b0;
        bus_rdata_i = '0;
        bus_rply_i  = 1'b0;
        reply_delay = -1;
        void'($urandom(RAND_SEED));

        // double operand: instr, branch, src, dst, word, cc, write address
        add_row(16'o012721, NO_BRANCH, 16'h1234, 16'hffff, 16'h1234, 4'b0000, DATA_A);
        add_row(16'o062721, NO_BRANCH, 16'h7fff, 16'h0001, 16'h8000, 4'b1010, DATA_A);
        add_row(16'o062721, NO_BRANCH, 16'hffff, 16'h0001, 16'h0000, 4'b0101, DATA_A);
        add_row(16'o162721, NO_BRANCH, 16'h0001, 16'h0000, 16'hffff, 4'b1001, DATA_A);
        add_row(16'o162721, NO_BRANCH, 16'h0001, 16'h8000, 16'h7fff, 4'b0010, DATA_A);
        add_row(16'o042721, NO_BRANCH, 16'h00f0, 16'h0ff0, 16'h0f00, 4'b0000, DATA_A);
        add_row(16'o052721, NO_BRANCH, 16'h8001, 16'h0100, 16'h8101, 4'b1000, DATA_A);
        // single operand, src unused
        add_row(16'o005021, NO_BRANCH, 16'h0000, 16'h5555, 16'h0000, 4'b0100, DATA_A);
        add_row(16'o005121, NO_BRANCH, 16'h0000, 16'h00ff, 16'hff00, 4'b1001, DATA_A);
        add_row(16'o005221, NO_BRANCH, 16'h0000, 16'h7fff, 16'h8000, 4'b1010, DATA_A);
        add_row(16'o005221, NO_BRANCH, 16'h0000, 16'hffff, 16'h0000, 4'b0100, DATA_A);
        add_row(16'o005321, NO_BRANCH, 16'h0000, 16'h8000, 16'h7fff, 4'b0010, DATA_A);
        add_row(16'o005321, NO_BRANCH, 16'h0000, 16'h0001, 16'h0000, 4'b0100, DATA_A);
        add_row(16'o005321, NO_BRANCH, 16'h0000, 16'h0000, 16'hffff, 4'b1000, DATA_A);
        add_row(16'o005421, NO_BRANCH, 16'h0000, 16'h0001, 16'hffff, 4'b1001, DATA_A);
        add_row(16'o005421, NO_BRANCH, 16'h0000, 16'h8000, 16'h8000, 4'b1011, DATA_A);
        // tst and cmp leave memory alone
        add_row(16'o005721, NO_BRANCH, 16'h0000, 16'h8000, 16'h8000, 4'b1000, NO_WRITE);
        add_row(16'o022721, NO_BRANCH, 16'h0005, 16'h0007, 16'h0007, 4'b1001, NO_WRITE);
        add_row(16'o022721, NO_BRANCH, 16'h8000, 16'h0001, 16'h0001, 4'b0010, NO_WRITE);
        // cmp then beq, bne, br
        add_row(16'o022721, 16'o001402, 16'h1111, 16'h1111, 16'h1111, 4'b0100, NO_WRITE);
        add_row(16'o022721, 16'o001002, 16'h1111, 16'h1111, BAD_WORD, 4'b1000, DATA_B);
        add_row(16'o022721, 16'o000402, 16'h0001, 16'h0002, 16'h0002, 4'b1001, NO_WRITE);
        add_row(16'o022721, 16'o001402, 16'h0001, 16'h0002, BAD_WORD, 4'b1001, DATA_B);

        for (int r = 0; r < rows.size(); r++)
            run_row(r);

        $display("Result: PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: src/lsi11_core.sv
`timescale 1ns/1ns
`default_nettype none

module lsi11_core import lsi11_pkg::*; (
    input  logic  clk,
    input  logic  reset_n,
    input  word_t bus_rdata_i,
    input  logic  bus_rply_i,
    output word_t bus_addr_o,
    output word_t bus_wdata_o,
    output logic  bus_rd_o,
    output logic  bus_wr_o,
    output logic  halted_o,
    output cc_t   cc_o
);

    lsi11_dec_if dec_bus ();
    lsi11_dp_if  dp_bus ();

    lsi11_decoder u_decoder (
        .ir_i (dp_bus.ir),      // decoded straight from the ir
        .dec  (dec_bus.dec)
    );

    lsi11_control u_control (
        .clk        (clk),
        .reset_n    (reset_n),
        .dec        (dec_bus.seq),
        .dp         (dp_bus.seq),
        .bus_rply_i (bus_rply_i),
        .bus_rd_o   (bus_rd_o),
        .bus_wr_o   (bus_wr_o),
        .halted_o   (halted_o)
    );

    lsi11_datapath u_datapath (
        .clk         (clk),
        .reset_n     (reset_n),
        .dp          (dp_bus.dp),
        .bus_rdata_i (bus_rdata_i),
        .bus_addr_o  (bus_addr_o),
        .bus_wdata_o (bus_wdata_o),
        .cc_o        (cc_o),
        .dec_i       (dec_bus.seq)
    );

endmodule

`default_nettype wire

// File: src/lsi11_datapath.sv
`timescale 1ns/1ns
`default_nettype none

module lsi11_datapath import lsi11_pkg::*; (
    input  logic      clk,
    input  logic      reset_n,
    lsi11_dp_if.dp    dp,
    input  word_t     bus_rdata_i,
    output word_t     bus_addr_o,
    output word_t     bus_wdata_o,
    output cc_t       cc_o,
    lsi11_dec_if.seq  dec_i
);

    word_t    regs [NUM_REGS];      // r7 is the pc
    word_t    src_q;
    word_t    dst_q;
    word_t    adr_q;
    word_t    ir_q;
    cc_t      cc_q;

    reg_idx_t sel_idx;
    mode_t    sel_mode;
    word_t    sel_val;
    word_t    opnd_data;
    word_t    pc_ofs;
    word_t    alu_res;
    cc_t      alu_cc;

    assign sel_idx   = (dp.opnd_sel == OPND_SRC) ? dec_i.src_reg : dec_i.dst_reg;
    assign sel_mode  = (dp.opnd_sel == OPND_SRC) ? dec_i.src_mode : dec_i.dst_mode;
    assign sel_val   = regs[sel_idx];
    assign opnd_data = (sel_mode == 3'd0) ? sel_val : bus_rdata_i;  // register or memory
    assign pc_ofs    = {{7{ir_q[7]}}, ir_q[7:0], 1'b0};             // 2 * signed offset

    lsi11_alu u_alu (
        .op_i     (dp.alu_op),
        .a_i      (src_q),
        .b_i      (dst_q),
        .cc_i     (cc_q),
        .result_o (alu_res),
        .cc_o     (alu_cc)
    );

    // ====================
    // register file and latches
    always_ff @(posedge clk) begin
        if (dp.boot_pc)
            regs[PC_IDX] <= BOOT_PC;
        if (dp.pc_step)
            regs[PC_IDX] <= regs[PC_IDX] + WORD_STEP;
        if (dp.pc_branch)
            regs[PC_IDX] <= regs[PC_IDX] + pc_ofs;
        if (dp.reg_step)
            regs[sel_idx] <= sel_val + WORD_STEP;
        if (dp.write_reg)
            regs[dec_i.dst_reg] <= alu_res;
        if (dp.load_ir)  ir_q  <= bus_rdata_i;
        if (dp.load_src) src_q <= opnd_data;
        if (dp.load_dst) dst_q <= opnd_data;
        if (dp.load_adr) adr_q <= sel_val;
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n)
            cc_q <= 4'b0000;
        else if (dp.load_cc)
            cc_q <= alu_cc;
    end

    // branch condition from z
    always_comb begin
        case (dec_i.branch_cond)
            BR_NE:   dp.branch_taken = ~cc_q[2];
            BR_EQ:   dp.branch_taken = cc_q[2];
            default: dp.branch_taken = 1'b1;
        endcase
    end

    assign dp.ir       = ir_q;
    assign bus_addr_o  = (dp.bus_addr_sel == ADDR_ADR) ? adr_q : regs[PC_IDX];
    assign bus_wdata_o = alu_res;
    assign cc_o        = cc_q;

endmodule

`default_nettype wire

// File: src/lsi11_alu.sv
`timescale 1ns/1ns
`default_nettype none

module lsi11_alu import lsi11_pkg::*; (
    input  alu_op_e op_i,
    input  word_t   a_i,        // source operand
    input  word_t   b_i,        // destination operand
    input  cc_t     cc_i,
    output word_t   result_o,
    output cc_t     cc_o
);

    logic [16:0] add_ext;
    logic [16:0] sub_ext;       // dst - src
    logic [16:0] cmp_ext;       // src - dst
    word_t       res;
    logic        v;
    logic        c;

    assign add_ext = {1'b0, a_i} + {1'b0, b_i};
    assign sub_ext = {1'b0, b_i} - {1'b0, a_i};
    assign cmp_ext = {1'b0, a_i} - {1'b0, b_i};

    always_comb begin
        res = b_i;
        v   = 1'b0;
        c   = cc_i[0];          // carry kept unless the op sets it

        case (op_i)
            ALU_MOV: res = a_i;
            ALU_CLR: begin res = 16'h0000; c = 1'b0; end
            ALU_COM: begin res = ~b_i; c = 1'b1; end
            ALU_INC: begin
                res = b_i + 16'h0001;
                v   = (b_i == 16'h7fff);
            end
            ALU_DEC: begin
                res = b_i - 16'h0001;
                v   = (b_i == 16'h8000);
            end
            ALU_NEG: begin
                res = 16'h0000 - b_i;
                v   = (res == 16'h8000);
                c   = (res != 16'h0000);
            end
            ALU_TST: c = 1'b0;
            ALU_ADD: begin
                res = add_ext[15:0];
                v   = (a_i[15] == b_i[15]) && (res[15] != a_i[15]);
                c   = add_ext[16];
            end
            ALU_SUB: begin
                res = sub_ext[15:0];
                v   = (a_i[15] != b_i[15]) && (res[15] == a_i[15]);
                c   = sub_ext[16];      // borrow
            end
            ALU_CMP: begin
                res = cmp_ext[15:0];
                v   = (a_i[15] != b_i[15]) && (res[15] == b_i[15]);
                c   = cmp_ext[16];
            end
            ALU_BIC: res = b_i & ~a_i;
            ALU_BIS: res = b_i | a_i;
            default: res = b_i;
        endcase
    end

    assign result_o = res;
    assign cc_o     = {res[15], (res == 16'h0000), v, c};

endmodule

`default_nettype wire

// File: src/lsi11_control.sv
`timescale 1ns/1ns
`default_nettype none

module lsi11_control import lsi11_pkg::*; (
    input  logic      clk,
    input  logic      reset_n,
    lsi11_dec_if.seq  dec,
    lsi11_dp_if.seq   dp,
    input  logic      bus_rply_i,
    output logic      bus_rd_o,
    output logic      bus_wr_o,
    output logic      halted_o
);

    seq_state_e state_q, state_d;
    logic       mem_phase_q, mem_phase_d;  // operand fetch: address latched, read pending
    logic       gap_q;                     // strobe kept low one cycle after a transfer
    logic       bus_ack;
    logic       opnd_is_src;
    mode_t      opnd_mode;

    assign bus_ack     = bus_rply_i & ~gap_q;
    assign opnd_is_src = (state_q == SRC_READ);
    assign opnd_mode   = opnd_is_src ? dec.src_mode : dec.dst_mode;
    assign halted_o    = (state_q == HALTED);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state_q     <= BOOT;
            mem_phase_q <= 1'b0;
            gap_q       <= 1'b0;
        end else begin
            state_q     <= state_d;
            mem_phase_q <= mem_phase_d;
            gap_q       <= (bus_rd_o | bus_wr_o) & bus_rply_i;
        end
    end

    // ====================
    // next state and datapath commands
    always_comb begin
        state_d         = state_q;
        mem_phase_d     = mem_phase_q;
        dp.boot_pc      = 1'b0;
        dp.load_ir      = 1'b0;
        dp.pc_step      = 1'b0;
        dp.pc_branch    = 1'b0;
        dp.opnd_sel     = opnd_is_src ? OPND_SRC : OPND_DST;
        dp.reg_step     = 1'b0;
        dp.load_src     = 1'b0;
        dp.load_dst     = 1'b0;
        dp.load_adr     = 1'b0;
        dp.alu_op       = dec.alu_op;
        dp.load_cc      = 1'b0;
        dp.write_reg    = 1'b0;
        dp.bus_addr_sel = ADDR_PC;
        bus_rd_o        = 1'b0;
        bus_wr_o        = 1'b0;

        case (state_q)
            BOOT: begin
                dp.boot_pc = 1'b1;
                state_d    = FETCH;
            end

            FETCH: begin
                bus_rd_o = ~gap_q;                  // read at pc
                if (bus_ack) begin
                    dp.load_ir = 1'b1;
                    dp.pc_step = 1'b1;
                    state_d    = DECODE;
                end
            end

            DECODE: begin
                if (!dec.legal || dec.instr_class == CLS_HALT)
                    state_d = HALTED;
                else if (dec.instr_class == CLS_BRANCH)
                    state_d = BRANCH;
                else if (dec.instr_class == CLS_DOUBLE)
                    state_d = SRC_READ;
                else
                    state_d = DST_READ;
            end

            // both operand fields share one sequence
            SRC_READ, DST_READ: begin
                if (opnd_mode == 3'd0) begin
                    dp.load_src = opnd_is_src;
                    dp.load_dst = ~opnd_is_src;
                    state_d     = opnd_is_src ? DST_READ : EXECUTE;
                end else if (!mem_phase_q) begin
                    dp.load_adr = 1'b1;             // adr <= rn
                    dp.reg_step = 1'b1;             // rn <= rn + 2
                    mem_phase_d = 1'b1;
                end else begin
                    dp.bus_addr_sel = ADDR_ADR;
                    bus_rd_o        = ~gap_q;
                    if (bus_ack) begin
                        dp.load_src = opnd_is_src;
                        dp.load_dst = ~opnd_is_src;
                        mem_phase_d = 1'b0;
                        state_d     = opnd_is_src ? DST_READ : EXECUTE;
                    end
                end
            end

            EXECUTE: begin
                dp.load_cc = 1'b1;
                if (dec.alu_op == ALU_TST || dec.alu_op == ALU_CMP)
                    state_d = FETCH;                // no result to store
                else
                    state_d = WRITEBACK;
            end

            WRITEBACK: begin
                if (dec.dst_mode == 3'd0) begin
                    dp.write_reg = 1'b1;
                    state_d      = FETCH;
                end else begin
                    dp.bus_addr_sel = ADDR_ADR;     // write back at adr
                    bus_wr_o        = ~gap_q;
                    if (bus_ack)
                        state_d = FETCH;
                end
            end

            BRANCH: begin
                dp.pc_branch = dp.branch_taken;
                state_d      = FETCH;
            end

            HALTED: state_d = HALTED;              // only reset leaves

            default: state_d = HALTED;
        endcase
    end

endmodule

`default_nettype wire

// File: src/lsi11_decoder.sv
`timescale 1ns/1ns
`default_nettype none

module lsi11_decoder import lsi11_pkg::*; (
    input  word_t       ir_i,
    lsi11_dec_if.dec    dec
);

    // only register and autoincrement modes are supported
    function automatic logic mode_ok(input mode_t m);
        mode_ok = (m == 3'd0) || (m == 3'd2);
    endfunction

    assign dec.src_mode = ir_i[11:9];
    assign dec.src_reg  = ir_i[8:6];
    assign dec.dst_mode = ir_i[5:3];
    assign dec.dst_reg  = ir_i[2:0];

    always_comb begin
        dec.instr_class = CLS_HALT;
        dec.alu_op      = ALU_MOV;
        dec.branch_cond = BR_ALWAYS;
        dec.legal       = 1'b0;

        case (ir_i[15:12])
            4'b0001: begin dec.instr_class = CLS_DOUBLE; dec.alu_op = ALU_MOV; end
            4'b0010: begin dec.instr_class = CLS_DOUBLE; dec.alu_op = ALU_CMP; end
            4'b0100: begin dec.instr_class = CLS_DOUBLE; dec.alu_op = ALU_BIC; end
            4'b0101: begin dec.instr_class = CLS_DOUBLE; dec.alu_op = ALU_BIS; end
            4'b0110: begin dec.instr_class = CLS_DOUBLE; dec.alu_op = ALU_ADD; end
            4'b1110: begin dec.instr_class = CLS_DOUBLE; dec.alu_op = ALU_SUB; end
            4'b0000: begin
                if (ir_i == 16'h0000) begin
                    dec.legal = 1'b1;                  // halt
                end else if (ir_i[11:8] inside {4'h1, 4'h2, 4'h3}) begin
                    dec.instr_class = CLS_BRANCH;
                    dec.legal       = 1'b1;
                    case (ir_i[9:8])
                        2'b10:   dec.branch_cond = BR_NE;
                        2'b11:   dec.branch_cond = BR_EQ;
                        default: dec.branch_cond = BR_ALWAYS;
                    endcase
                end else if (ir_i[11:6] inside {6'o50, 6'o51, 6'o52, 6'o53, 6'o54, 6'o57}) begin
                    dec.instr_class = CLS_SINGLE;
                    case (ir_i[8:6])
                        3'o0:    dec.alu_op = ALU_CLR;
                        3'o1:    dec.alu_op = ALU_COM;
                        3'o2:    dec.alu_op = ALU_INC;
                        3'o3:    dec.alu_op = ALU_DEC;
                        3'o4:    dec.alu_op = ALU_NEG;
                        default: dec.alu_op = ALU_TST;
                    endcase
                    dec.legal = mode_ok(ir_i[5:3]);
                end
            end
            default: ;                                 // unsupported, stays illegal
        endcase

        if (dec.instr_class == CLS_DOUBLE) begin
            dec.legal = mode_ok(ir_i[11:9]) && mode_ok(ir_i[5:3]);
        end
    end

endmodule

`default_nettype wire

// File: src/lsi11_dp_if.sv
`timescale 1ns/1ns
`default_nettype none

interface lsi11_dp_if import lsi11_pkg::*; ();

    // ====================
    // sequencer commands
    logic          boot_pc;
    logic          load_ir;
    logic          pc_step;
    logic          pc_branch;
    opnd_sel_e     opnd_sel;
    logic          reg_step;     // autoincrement of the selected register
    logic          load_src;
    logic          load_dst;
    logic          load_adr;
    alu_op_e       alu_op;
    logic          load_cc;
    logic          write_reg;
    bus_addr_sel_e bus_addr_sel;

    // status back from the datapath
    logic          branch_taken;
    word_t         ir;

    modport seq (output boot_pc, load_ir, pc_step, pc_branch, opnd_sel, reg_step, load_src,
                        load_dst, load_adr, alu_op, load_cc, write_reg, bus_addr_sel,
                 input  branch_taken);
    modport dp  (input  boot_pc, load_ir, pc_step, pc_branch, opnd_sel, reg_step, load_src,
                        load_dst, load_adr, alu_op, load_cc, write_reg, bus_addr_sel,
                 output branch_taken, ir);

endinterface

`default_nettype wire

// File: src/lsi11_dec_if.sv
`timescale 1ns/1ns
`default_nettype none

// decoded instruction fields, decoder -> sequencer and datapath
interface lsi11_dec_if import lsi11_pkg::*; ();

    instr_class_e instr_class;
    alu_op_e      alu_op;
    mode_t        src_mode;
    reg_idx_t     src_reg;
    mode_t        dst_mode;
    reg_idx_t     dst_reg;
    branch_e      branch_cond;
    logic         legal;     // low for unsupported opcode or mode

    modport dec (output instr_class, alu_op, src_mode, src_reg, dst_mode, dst_reg,
                 branch_cond, legal);
    modport seq (input  instr_class, alu_op, src_mode, src_reg, dst_mode, dst_reg,
                 branch_cond, legal);

endinterface

`default_nettype wire

// File: src/lsi11_pkg.sv
`default_nettype none

package lsi11_pkg;

    // ====================
    // widths with a meaning
    typedef logic [15:0] word_t;     // data word or address
    typedef logic [2:0]  reg_idx_t;  // r0..r7, r7 is the pc
    typedef logic [2:0]  mode_t;
    typedef logic [3:0]  cc_t;       // n z v c

    localparam word_t    BOOT_PC   = 16'h0000;
    localparam reg_idx_t PC_IDX    = 3'd7;
    localparam word_t    WORD_STEP = 16'd2;  // autoincrement and pc step
    localparam int       NUM_REGS  = 8;

    // ====================
    // enums
    typedef enum logic [3:0] {
        ALU_MOV, ALU_CLR, ALU_COM, ALU_INC, ALU_DEC, ALU_NEG,
        ALU_TST, ALU_ADD, ALU_SUB, ALU_CMP, ALU_BIC, ALU_BIS
    } alu_op_e;

    typedef enum logic [1:0] {CLS_SINGLE, CLS_DOUBLE, CLS_BRANCH, CLS_HALT} instr_class_e;

    typedef enum logic [1:0] {BR_ALWAYS, BR_NE, BR_EQ} branch_e;

    typedef enum logic [3:0] {
        BOOT, FETCH, DECODE, SRC_READ, DST_READ,
        EXECUTE, WRITEBACK, BRANCH, HALTED
    } seq_state_e;

    typedef enum logic {OPND_SRC, OPND_DST} opnd_sel_e;

    typedef enum logic {ADDR_PC, ADDR_ADR} bus_addr_sel_e;

endpackage

`default_nettype wire
